/* hdl/rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

  //////////////////////////////////////////////////
  // Instruction word and field types
  //////////////////////////////////////////////////

  typedef logic [31:0] instr_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [4:0]  opcode_t;
  typedef logic [2:0]  funct3_t;
  typedef logic [6:0]  funct7_t;

  // Field positions, lowest bit of each field
  localparam int OPC_LSB    = 2;
  localparam int RD_LSB     = 7;
  localparam int FUNCT3_LSB = 12;
  localparam int RS1_LSB    = 15;
  localparam int RS2_LSB    = 20;
  localparam int FUNCT7_LSB = 25;

  //////////////////////////////////////////////////
  // Major opcodes, instr[6:2]
  //////////////////////////////////////////////////

  localparam opcode_t OPC_LOAD     = 5'b00000;
  localparam opcode_t OPC_MISC_MEM = 5'b00011;
  localparam opcode_t OPC_OP_IMM   = 5'b00100;
  localparam opcode_t OPC_AUIPC    = 5'b00101;
  localparam opcode_t OPC_OP_IMM32 = 5'b00110;
  localparam opcode_t OPC_STORE    = 5'b01000;
  localparam opcode_t OPC_OP       = 5'b01100;
  localparam opcode_t OPC_LUI      = 5'b01101;
  localparam opcode_t OPC_OP32     = 5'b01110;
  localparam opcode_t OPC_BRANCH   = 5'b11000;
  localparam opcode_t OPC_JALR     = 5'b11001;
  localparam opcode_t OPC_JAL      = 5'b11011;
  localparam opcode_t OPC_SYSTEM   = 5'b11100;

  // funct7 values accepted on OP
  localparam funct7_t FUNCT7_BASE = 7'h00;
  localparam funct7_t FUNCT7_ALT  = 7'h20;

  // Only ADD/SUB and SRL/SRA use the alternate funct7
  localparam funct3_t FUNCT3_ADD_SUB = 3'd0;
  localparam funct3_t FUNCT3_SRL_SRA = 3'd5;

  //////////////////////////////////////////////////
  // Full words for the environment instructions
  //////////////////////////////////////////////////

  localparam instr_t ECALL  = 32'h0000_0073;
  localparam instr_t EBREAK = 32'h0010_0073;

endpackage

`default_nettype wire

/* hdl/id_pipe_pkg.sv */
`default_nettype none

package id_pipe_pkg;

  //////////////////////////////////////////////////
  // Operand source selects
  //////////////////////////////////////////////////

  typedef enum logic [1:0] {
    OPA_RF   = 2'd0,
    OPA_PC   = 2'd1,
    OPA_ZERO = 2'd2
  } opa_sel_e;

  // RS1IDX feeds the rs1 field itself, zero-extended (CSR immediates)
  typedef enum logic [1:0] {
    OPB_RF     = 2'd0,
    OPB_IMM    = 2'd1,
    OPB_RS1IDX = 2'd2
  } opb_sel_e;

  // Immediate is always built at full RV64 width
  typedef logic [63:0] imm_t;

  //////////////////////////////////////////////////
  // Stage records
  //////////////////////////////////////////////////

  // One downstream stage as seen from decode
  typedef struct packed {
    rv_isa_pkg::instr_t instr;
    logic               bubble;
    logic               writes_rd;
  } stage_info_t;

  typedef struct packed {
    logic illegal;
    logic breakpoint;
    logic ecall;
  } id_exc_t;

  typedef struct packed {
    logic ex_a;
    logic ex_b;
    logic mem_a;
    logic mem_b;
    logic wb_a;
    logic wb_b;
  } bypass_t;

  typedef struct packed {
    logic     uses_rs1;
    logic     uses_rs2;
    logic     is_load;
    logic     writes_rd;
    opa_sel_e opa_sel;
    opb_sel_e opb_sel;
    id_exc_t  exc;
    imm_t     imm;
  } decode_t;

endpackage

`default_nettype wire

/* hdl/instr_decode.sv */
`timescale 1ns/1ns
`default_nettype none

module instr_decode #(
  parameter int XLEN = 64
) (
  input  rv_isa_pkg::instr_t   instr,
  output id_pipe_pkg::decode_t dec
);

  localparam bit RV32 = (XLEN == 32);

  rv_isa_pkg::opcode_t opcode;
  rv_isa_pkg::funct3_t funct3;
  rv_isa_pkg::funct7_t funct7;
  id_pipe_pkg::imm_t   imm_i;
  id_pipe_pkg::imm_t   imm_u;
  logic                illegal;

  assign opcode = instr[rv_isa_pkg::OPC_LSB +: 5];
  assign funct3 = instr[rv_isa_pkg::FUNCT3_LSB +: 3];
  assign funct7 = instr[rv_isa_pkg::FUNCT7_LSB +: 7];

  // Sign-extended I and U immediates
  assign imm_i = {{52{instr[31]}}, instr[31:20]};
  assign imm_u = {{32{instr[31]}}, instr[31:12], 12'b0};

  //////////////////////////////////////////////////
  // Classification and operand selects
  //////////////////////////////////////////////////

  always_comb begin
    dec           = '0;
    dec.uses_rs1  = 1'b1;
    dec.opa_sel   = id_pipe_pkg::OPA_RF;
    dec.opb_sel   = id_pipe_pkg::OPB_RF;
    case (opcode)
      rv_isa_pkg::OPC_LOAD: begin
        dec.is_load   = 1'b1;
        dec.writes_rd = 1'b1;
        dec.opb_sel   = id_pipe_pkg::OPB_IMM;
      end
      rv_isa_pkg::OPC_OP_IMM, rv_isa_pkg::OPC_OP_IMM32, rv_isa_pkg::OPC_JALR: begin
        dec.writes_rd = 1'b1;
        dec.opb_sel   = id_pipe_pkg::OPB_IMM;
      end
      rv_isa_pkg::OPC_AUIPC: begin
        dec.uses_rs1  = 1'b0;
        dec.writes_rd = 1'b1;
        dec.opa_sel   = id_pipe_pkg::OPA_PC;
        dec.opb_sel   = id_pipe_pkg::OPB_IMM;
      end
      rv_isa_pkg::OPC_LUI: begin
        dec.uses_rs1  = 1'b0;
        dec.writes_rd = 1'b1;
        dec.opa_sel   = id_pipe_pkg::OPA_ZERO;
        dec.opb_sel   = id_pipe_pkg::OPB_IMM;
      end
      rv_isa_pkg::OPC_OP, rv_isa_pkg::OPC_OP32: begin
        dec.uses_rs2  = 1'b1;
        dec.writes_rd = 1'b1;
      end
      rv_isa_pkg::OPC_STORE, rv_isa_pkg::OPC_BRANCH: begin
        dec.uses_rs2  = 1'b1;
      end
      rv_isa_pkg::OPC_JAL: begin
        dec.uses_rs1  = 1'b0;
        dec.writes_rd = 1'b1;
      end
      rv_isa_pkg::OPC_SYSTEM: begin
        dec.writes_rd = 1'b1;
        dec.opb_sel   = id_pipe_pkg::OPB_RS1IDX;
      end
      default: begin
      end
    endcase

    // U-type gets the upper immediate, all others the I form
    dec.imm = (opcode == rv_isa_pkg::OPC_LUI || opcode == rv_isa_pkg::OPC_AUIPC) ? imm_u : imm_i;

    dec.exc.illegal    = illegal;
    dec.exc.breakpoint = (instr == rv_isa_pkg::EBREAK);
    dec.exc.ecall      = (instr == rv_isa_pkg::ECALL);
  end

  //////////////////////////////////////////////////
  // Legality
  //////////////////////////////////////////////////

  always_comb begin
    illegal = (instr[1:0] != 2'b11);
    case (opcode)
      rv_isa_pkg::OPC_MISC_MEM, rv_isa_pkg::OPC_OP_IMM, rv_isa_pkg::OPC_AUIPC,
      rv_isa_pkg::OPC_LUI, rv_isa_pkg::OPC_JALR, rv_isa_pkg::OPC_JAL: begin
      end
      // Word-sized ALU ops exist on RV64 only
      rv_isa_pkg::OPC_OP_IMM32, rv_isa_pkg::OPC_OP32: illegal |= RV32;
      rv_isa_pkg::OPC_BRANCH: illegal |= (funct3 == 3'd2) || (funct3 == 3'd3);
      rv_isa_pkg::OPC_LOAD: begin
        illegal |= (funct3 == 3'd7) || (RV32 && (funct3 == 3'd3 || funct3 == 3'd6));
      end
      rv_isa_pkg::OPC_STORE: illegal |= (funct3 > 3'd3) || (RV32 && funct3 == 3'd3);
      rv_isa_pkg::OPC_OP: begin
        illegal |= (funct7 != rv_isa_pkg::FUNCT7_BASE) && (funct7 != rv_isa_pkg::FUNCT7_ALT);
        illegal |= (funct7 == rv_isa_pkg::FUNCT7_ALT) &&
                   (funct3 != rv_isa_pkg::FUNCT3_ADD_SUB) &&
                   (funct3 != rv_isa_pkg::FUNCT3_SRL_SRA);
      end
      // No CSR support, so ECALL and EBREAK are the only SYSTEM words
      rv_isa_pkg::OPC_SYSTEM: begin
        illegal |= (instr != rv_isa_pkg::ECALL) && (instr != rv_isa_pkg::EBREAK);
      end
      default: illegal = 1'b1;
    endcase
  end

endmodule

`default_nettype wire

/* hdl/hazard_detect.sv */
`timescale 1ns/1ns
`default_nettype none

module hazard_detect (
  input  logic                     clk,
  input  logic                     rstn,
  input  rv_isa_pkg::instr_t       if_instr,
  input  logic                     if_bubble,
  input  id_pipe_pkg::decode_t     dec,
  input  id_pipe_pkg::stage_info_t id_info,
  input  id_pipe_pkg::stage_info_t ex_info,
  input  id_pipe_pkg::stage_info_t mem_info,
  input  logic                     ex_stall,
  input  logic                     flush,
  output id_pipe_pkg::bypass_t     byp,
  output logic                     id_stall
);

  rv_isa_pkg::reg_addr_t rs1;
  rv_isa_pkg::reg_addr_t rs2;

  assign rs1 = if_instr[rv_isa_pkg::RS1_LSB +: 5];
  assign rs2 = if_instr[rv_isa_pkg::RS2_LSB +: 5];

  // Source matches a live, nonzero destination of that stage
  function automatic logic fwd_hit(rv_isa_pkg::reg_addr_t src,
                                   id_pipe_pkg::stage_info_t st);
    rv_isa_pkg::reg_addr_t rd;
    rd = st.instr[rv_isa_pkg::RD_LSB +: 5];
    return (src == rd) && (rd != '0) && st.writes_rd && !st.bubble;
  endfunction

  // Valid load in that stage whose rd is needed now
  function automatic logic load_use(id_pipe_pkg::stage_info_t st,
                                    id_pipe_pkg::decode_t d,
                                    rv_isa_pkg::reg_addr_t a,
                                    rv_isa_pkg::reg_addr_t b);
    rv_isa_pkg::reg_addr_t rd;
    logic                  is_load;
    rd      = st.instr[rv_isa_pkg::RD_LSB +: 5];
    is_load = (st.instr[rv_isa_pkg::OPC_LSB +: 5] == rv_isa_pkg::OPC_LOAD) && !st.bubble;
    return is_load && ((d.uses_rs1 && a == rd) || (d.uses_rs2 && b == rd));
  endfunction

  //////////////////////////////////////////////////
  // Forwarding switches
  //////////////////////////////////////////////////

  // ID result arrives from EX, EX result from MEM, MEM result from WB
  always_comb begin
    byp.ex_a  = dec.uses_rs1 && fwd_hit(rs1, id_info);
    byp.ex_b  = dec.uses_rs2 && fwd_hit(rs2, id_info);
    byp.mem_a = dec.uses_rs1 && fwd_hit(rs1, ex_info);
    byp.mem_b = dec.uses_rs2 && fwd_hit(rs2, ex_info);
    byp.wb_a  = dec.uses_rs1 && fwd_hit(rs1, mem_info);
    byp.wb_b  = dec.uses_rs2 && fwd_hit(rs2, mem_info);
  end

  //////////////////////////////////////////////////
  // Load-use stall
  //////////////////////////////////////////////////

  always_comb begin
    if (flush) begin
      id_stall = 1'b0;
    end else if (ex_stall) begin
      // Bubbles coming out of IF never need holding
      id_stall = ~if_bubble;
    end else begin
      id_stall = load_use(id_info, dec, rs1, rs2) || load_use(ex_info, dec, rs1, rs2);
    end
  end

  // A live load in ID always carries writes_rd, so stall and forwarding agree
  assert property (@(posedge clk) disable iff (!rstn)
                   !id_info.bubble &&
                   (id_info.instr[rv_isa_pkg::OPC_LSB +: 5] == rv_isa_pkg::OPC_LOAD)
                   |-> id_info.writes_rd)
    else $error("hazard_detect: live load in ID without writes_rd");

endmodule

`default_nettype wire

/* hdl/id_register.sv */
`timescale 1ns/1ns
`default_nettype none

module id_register #(
  parameter int XLEN = 64
) (
  input  logic                     clk,
  input  logic                     rstn,
  input  logic                     ex_stall,
  input  logic                     flush,
  input  logic [XLEN-1:0]          flush_pc,
  input  logic [XLEN-1:0]          if_pc,
  input  rv_isa_pkg::instr_t       if_instr,
  input  logic                     if_bubble,
  input  id_pipe_pkg::decode_t     dec,
  input  id_pipe_pkg::bypass_t     byp,
  input  logic                     id_stall,
  output logic [XLEN-1:0]          id_pc,
  output rv_isa_pkg::instr_t       id_instr,
  output id_pipe_pkg::stage_info_t id_info,
  output id_pipe_pkg::decode_t     id_dec_out,
  output id_pipe_pkg::bypass_t     id_byp,
  output logic                     id_bubble_out
);

  logic                 bubble_q;
  id_pipe_pkg::decode_t dec_next;
  id_pipe_pkg::decode_t dec_q;
  id_pipe_pkg::bypass_t byp_q;

  // Causes only travel with a real, unstalled instruction
  always_comb begin
    dec_next = dec;
    if (if_bubble || id_stall || flush) begin
      dec_next.exc = '0;
    end
  end

  //////////////////////////////////////////////////
  // PC and bubble
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      id_pc    <= '0;
      bubble_q <= 1'b1;
    end else if (flush) begin
      id_pc    <= flush_pc;
      bubble_q <= 1'b1;
    end else if (!ex_stall) begin
      if (id_stall) begin
        // Insert a bubble, IF presents the same PC again
        bubble_q <= 1'b1;
      end else begin
        id_pc    <= if_pc;
        bubble_q <= if_bubble;
      end
    end
  end

  //////////////////////////////////////////////////
  // Decode result and switches
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      dec_q <= '0;
      byp_q <= '0;
    end else if (!ex_stall) begin
      dec_q <= dec_next;
      byp_q <= byp;
    end else if (flush) begin
      dec_q.exc <= '0;
    end
  end

  always_ff @(posedge clk) begin
    if (!ex_stall) begin
      id_instr <= if_instr;
    end
  end

  always_comb begin
    id_info.instr     = id_instr;
    id_info.bubble    = bubble_q;
    id_info.writes_rd = dec_q.writes_rd;
  end

  assign id_dec_out    = dec_q;
  assign id_byp        = byp_q;
  assign id_bubble_out = bubble_q | ex_stall | flush;

  // A bubble never carries an exception cause
  assert property (@(posedge clk) disable iff (!rstn) bubble_q |-> (dec_q.exc == '0))
    else $error("id_register: exception cause held by a bubble");

endmodule

`default_nettype wire

/* hdl/id_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module id_stage #(
  parameter int XLEN = 64
) (
  input  logic                     clk,
  input  logic                     rstn,
  input  logic                     ex_stall,
  input  logic                     flush,
  input  logic [XLEN-1:0]          flush_pc,
  input  logic [XLEN-1:0]          if_pc,
  input  rv_isa_pkg::instr_t       if_instr,
  input  logic                     if_bubble,
  input  id_pipe_pkg::stage_info_t ex_info,
  input  id_pipe_pkg::stage_info_t mem_info,
  output logic [XLEN-1:0]          id_pc,
  output rv_isa_pkg::instr_t       id_instr,
  output id_pipe_pkg::decode_t     id_dec_out,
  output logic [XLEN-1:0]          id_imm,
  output id_pipe_pkg::bypass_t     id_byp,
  output logic                     id_bubble_out,
  output logic                     id_stall,
  output rv_isa_pkg::reg_addr_t    id_src1,
  output rv_isa_pkg::reg_addr_t    id_src2
);

  id_pipe_pkg::decode_t     dec;
  id_pipe_pkg::bypass_t     byp;
  id_pipe_pkg::stage_info_t id_info;

  instr_decode #(.XLEN(XLEN)) instr_decode_i (
    .instr (if_instr),
    .dec   (dec)
  );

  hazard_detect hazard_detect_i (
    .clk       (clk),
    .rstn      (rstn),
    .if_instr  (if_instr),
    .if_bubble (if_bubble),
    .dec       (dec),
    .id_info   (id_info),
    .ex_info   (ex_info),
    .mem_info  (mem_info),
    .ex_stall  (ex_stall),
    .flush     (flush),
    .byp       (byp),
    .id_stall  (id_stall)
  );

  id_register #(.XLEN(XLEN)) id_register_i (
    .clk           (clk),
    .rstn          (rstn),
    .ex_stall      (ex_stall),
    .flush         (flush),
    .flush_pc      (flush_pc),
    .if_pc         (if_pc),
    .if_instr      (if_instr),
    .if_bubble     (if_bubble),
    .dec           (dec),
    .byp           (byp),
    .id_stall      (id_stall),
    .id_pc         (id_pc),
    .id_instr      (id_instr),
    .id_info       (id_info),
    .id_dec_out    (id_dec_out),
    .id_byp        (id_byp),
    .id_bubble_out (id_bubble_out)
  );

  // Immediate cut to the machine width
  assign id_imm = id_dec_out.imm[XLEN-1:0];

  // Register file reads the held instruction while EX is stalled
  assign id_src1 = ex_stall ? id_instr[rv_isa_pkg::RS1_LSB +: 5]
                            : if_instr[rv_isa_pkg::RS1_LSB +: 5];
  assign id_src2 = ex_stall ? id_instr[rv_isa_pkg::RS2_LSB +: 5]
                            : if_instr[rv_isa_pkg::RS2_LSB +: 5];

endmodule

`default_nettype wire

/* test/id_stage_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module id_stage_tb;

  localparam int XLEN         = 64;
  localparam int RESET_CYCLES = 5;
  localparam int NUM_CYCLES   = 2500;
  // Budget of 3000 cycles at 4 ns, plus margin
  localparam int WATCHDOG_NS  = 3000 * 4 + 400;
  localparam rv_isa_pkg::instr_t NOP = 32'h0000_0013;

  localparam rv_isa_pkg::opcode_t OPCODE_TABLE [13] = '{
    rv_isa_pkg::OPC_LOAD, rv_isa_pkg::OPC_MISC_MEM, rv_isa_pkg::OPC_OP_IMM,
    rv_isa_pkg::OPC_AUIPC, rv_isa_pkg::OPC_OP_IMM32, rv_isa_pkg::OPC_STORE,
    rv_isa_pkg::OPC_OP, rv_isa_pkg::OPC_LUI, rv_isa_pkg::OPC_OP32,
    rv_isa_pkg::OPC_BRANCH, rv_isa_pkg::OPC_JALR, rv_isa_pkg::OPC_JAL,
    rv_isa_pkg::OPC_SYSTEM
  };

  logic                     clk;
  logic                     rstn;
  logic                     ex_stall;
  logic                     flush;
  logic [XLEN-1:0]          flush_pc;
  logic [XLEN-1:0]          if_pc;
  rv_isa_pkg::instr_t       if_instr;
  logic                     if_bubble;
  id_pipe_pkg::stage_info_t ex_info;
  id_pipe_pkg::stage_info_t mem_info;
  logic [XLEN-1:0]          id_pc;
  rv_isa_pkg::instr_t       id_instr;
  id_pipe_pkg::decode_t     id_dec_out;
  logic [XLEN-1:0]          id_imm;
  id_pipe_pkg::bypass_t     id_byp;
  logic                     id_bubble_out;
  logic                     id_stall;
  rv_isa_pkg::reg_addr_t    id_src1;
  rv_isa_pkg::reg_addr_t    id_src2;

  // Reference ID state
  logic [XLEN-1:0]      m_pc;
  rv_isa_pkg::instr_t   m_instr;
  logic                 m_bubble;
  id_pipe_pkg::decode_t m_dec;
  id_pipe_pkg::bypass_t m_byp;

  int          errors;
  int          checks;
  int          cycle;
  logic [31:0] rng_state;

  id_stage #(.XLEN(XLEN)) id_stage_i (
    .clk           (clk),
    .rstn          (rstn),
    .ex_stall      (ex_stall),
    .flush         (flush),
    .flush_pc      (flush_pc),
    .if_pc         (if_pc),
    .if_instr      (if_instr),
    .if_bubble     (if_bubble),
    .ex_info       (ex_info),
    .mem_info      (mem_info),
    .id_pc         (id_pc),
    .id_instr      (id_instr),
    .id_dec_out    (id_dec_out),
    .id_imm        (id_imm),
    .id_byp        (id_byp),
    .id_bubble_out (id_bubble_out),
    .id_stall      (id_stall),
    .id_src1       (id_src1),
    .id_src2       (id_src2)
  );

  always #2 clk = ~clk;

  //////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////

  task automatic check_dec(input string name, input id_pipe_pkg::decode_t exp,
                           input id_pipe_pkg::decode_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED %s cycle %0d: expected %h, actual %h", name, cycle, exp, act);
    end
  endtask

  task automatic check_byp(input string name, input id_pipe_pkg::bypass_t exp,
                           input id_pipe_pkg::bypass_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED %s cycle %0d: expected %b, actual %b", name, cycle, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED %s cycle %0d: expected %b, actual %b", name, cycle, exp, act);
    end
  endtask

  task automatic check_pc(input string name, input logic [XLEN-1:0] exp,
                          input logic [XLEN-1:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED %s cycle %0d: expected %h, actual %h", name, cycle, exp, act);
    end
  endtask

  task automatic check_imm(input string name, input logic [XLEN-1:0] exp,
                           input logic [XLEN-1:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED %s cycle %0d: expected %h, actual %h", name, cycle, exp, act);
    end
  endtask

  task automatic check_instr(input string name, input rv_isa_pkg::instr_t exp,
                             input rv_isa_pkg::instr_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED %s cycle %0d: expected %h, actual %h", name, cycle, exp, act);
    end
  endtask

  task automatic check_reg(input string name, input rv_isa_pkg::reg_addr_t exp,
                           input rv_isa_pkg::reg_addr_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED %s cycle %0d: expected %0d, actual %0d", name, cycle, exp, act);
    end
  endtask

  //////////////////////////////////////////////////
  // Stimulus generation
  //////////////////////////////////////////////////

  function automatic logic [31:0] rand32();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  // Registers limited to x0..x3 so hazards are frequent
  function automatic rv_isa_pkg::instr_t gen_instr();
    logic [31:0]         r;
    logic [31:0]         s;
    logic [3:0]          idx;
    rv_isa_pkg::opcode_t op;
    rv_isa_pkg::funct7_t f7;
    r = rand32();
    s = rand32();
    if (r[3:0] == 4'd0) return s;
    if (r[3:0] == 4'd1) return rv_isa_pkg::ECALL;
    if (r[3:0] == 4'd2) return rv_isa_pkg::EBREAK;
    idx = 4'(r[31:8] % 24'd13);
    op  = OPCODE_TABLE[idx];
    case (r[5:4])
      2'd0:    f7 = 7'h00;
      2'd3:    f7 = s[31:25];
      default: f7 = 7'h20;
    endcase
    return {f7, 3'b000, s[21:20], 3'b000, s[16:15], s[14:12], 3'b000, s[8:7], op, 2'b11};
  endfunction

  function automatic id_pipe_pkg::stage_info_t gen_stage();
    id_pipe_pkg::stage_info_t st;
    logic [31:0]              r;
    st.instr     = gen_instr();
    r            = rand32();
    st.bubble    = (r[1:0] == 2'd0);
    st.writes_rd = r[2];
    return st;
  endfunction

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  function automatic id_pipe_pkg::decode_t model_decode(rv_isa_pkg::instr_t ins);
    id_pipe_pkg::decode_t d;
    rv_isa_pkg::opcode_t  op;
    rv_isa_pkg::funct3_t  f3;
    rv_isa_pkg::funct7_t  f7;
    logic                 ill;
    op = ins[6:2];
    f3 = ins[14:12];
    f7 = ins[31:25];
    d  = '0;
    d.uses_rs1  = !(op == rv_isa_pkg::OPC_LUI || op == rv_isa_pkg::OPC_AUIPC ||
                    op == rv_isa_pkg::OPC_JAL);
    d.uses_rs2  = op inside {rv_isa_pkg::OPC_OP, rv_isa_pkg::OPC_OP32,
                             rv_isa_pkg::OPC_BRANCH, rv_isa_pkg::OPC_STORE};
    d.is_load   = (op == rv_isa_pkg::OPC_LOAD);
    d.writes_rd = op inside {rv_isa_pkg::OPC_LOAD, rv_isa_pkg::OPC_OP_IMM,
                             rv_isa_pkg::OPC_AUIPC, rv_isa_pkg::OPC_OP_IMM32,
                             rv_isa_pkg::OPC_OP, rv_isa_pkg::OPC_LUI, rv_isa_pkg::OPC_OP32,
                             rv_isa_pkg::OPC_JALR, rv_isa_pkg::OPC_JAL,
                             rv_isa_pkg::OPC_SYSTEM};
    case (op)
      rv_isa_pkg::OPC_AUIPC: begin
        d.opa_sel = id_pipe_pkg::OPA_PC;
        d.opb_sel = id_pipe_pkg::OPB_IMM;
      end
      rv_isa_pkg::OPC_LUI: begin
        d.opa_sel = id_pipe_pkg::OPA_ZERO;
        d.opb_sel = id_pipe_pkg::OPB_IMM;
      end
      rv_isa_pkg::OPC_OP_IMM, rv_isa_pkg::OPC_OP_IMM32,
      rv_isa_pkg::OPC_LOAD, rv_isa_pkg::OPC_JALR: d.opb_sel = id_pipe_pkg::OPB_IMM;
      rv_isa_pkg::OPC_SYSTEM: d.opb_sel = id_pipe_pkg::OPB_RS1IDX;
      default: ;
    endcase
    if (op == rv_isa_pkg::OPC_LUI || op == rv_isa_pkg::OPC_AUIPC) begin
      d.imm = 64'($signed({ins[31:12], 12'h000}));
    end else begin
      d.imm = 64'($signed(ins[31:20]));
    end

    ill = (ins[1:0] != 2'b11) ||
          !(op inside {rv_isa_pkg::OPC_LOAD, rv_isa_pkg::OPC_MISC_MEM, rv_isa_pkg::OPC_OP_IMM,
                       rv_isa_pkg::OPC_AUIPC, rv_isa_pkg::OPC_OP_IMM32, rv_isa_pkg::OPC_STORE,
                       rv_isa_pkg::OPC_OP, rv_isa_pkg::OPC_LUI, rv_isa_pkg::OPC_OP32,
                       rv_isa_pkg::OPC_BRANCH, rv_isa_pkg::OPC_JALR, rv_isa_pkg::OPC_JAL,
                       rv_isa_pkg::OPC_SYSTEM});
    case (op)
      rv_isa_pkg::OPC_OP_IMM32, rv_isa_pkg::OPC_OP32: if (XLEN == 32) ill = 1'b1;
      rv_isa_pkg::OPC_BRANCH: if (f3 == 3'd2 || f3 == 3'd3) ill = 1'b1;
      rv_isa_pkg::OPC_LOAD: begin
        if (f3 == 3'd7 || (XLEN == 32 && (f3 == 3'd3 || f3 == 3'd6))) ill = 1'b1;
      end
      rv_isa_pkg::OPC_STORE: if (f3 > 3'd3 || (XLEN == 32 && f3 == 3'd3)) ill = 1'b1;
      rv_isa_pkg::OPC_OP: begin
        if (!(f7 == 7'h00 || f7 == 7'h20)) ill = 1'b1;
        if (f7 == 7'h20 && f3 != 3'd0 && f3 != 3'd5) ill = 1'b1;
      end
      rv_isa_pkg::OPC_SYSTEM: begin
        if (ins != rv_isa_pkg::ECALL && ins != rv_isa_pkg::EBREAK) ill = 1'b1;
      end
      default: ;
    endcase
    d.exc.illegal    = ill;
    d.exc.breakpoint = (ins == rv_isa_pkg::EBREAK);
    d.exc.ecall      = (ins == rv_isa_pkg::ECALL);
    return d;
  endfunction

  function automatic logic dest_match(rv_isa_pkg::reg_addr_t src,
                                      id_pipe_pkg::stage_info_t st);
    rv_isa_pkg::reg_addr_t rd;
    rd = st.instr[11:7];
    return !st.bubble && st.writes_rd && rd != 5'd0 && src == rd;
  endfunction

  function automatic id_pipe_pkg::bypass_t model_byp(rv_isa_pkg::instr_t ins,
      id_pipe_pkg::decode_t d, id_pipe_pkg::stage_info_t id_view,
      id_pipe_pkg::stage_info_t ex_view, id_pipe_pkg::stage_info_t mem_view);
    id_pipe_pkg::bypass_t b;
    b.ex_a  = d.uses_rs1 && dest_match(ins[19:15], id_view);
    b.ex_b  = d.uses_rs2 && dest_match(ins[24:20], id_view);
    b.mem_a = d.uses_rs1 && dest_match(ins[19:15], ex_view);
    b.mem_b = d.uses_rs2 && dest_match(ins[24:20], ex_view);
    b.wb_a  = d.uses_rs1 && dest_match(ins[19:15], mem_view);
    b.wb_b  = d.uses_rs2 && dest_match(ins[24:20], mem_view);
    return b;
  endfunction

  function automatic logic load_hazard(rv_isa_pkg::instr_t ins, id_pipe_pkg::decode_t d,
                                       id_pipe_pkg::stage_info_t st);
    rv_isa_pkg::reg_addr_t rd;
    rd = st.instr[11:7];
    if (st.bubble || st.instr[6:2] != rv_isa_pkg::OPC_LOAD) return 1'b0;
    return (d.uses_rs1 && ins[19:15] == rd) || (d.uses_rs2 && ins[24:20] == rd);
  endfunction

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    logic [31:0]              s;
    logic [31:0]              t;
    logic [31:0]              r;
    id_pipe_pkg::decode_t     d_m;
    id_pipe_pkg::bypass_t     b_m;
    id_pipe_pkg::stage_info_t id_view;
    logic                     stall_m;
    rng_state = 32'd60906;
    errors    = 0;
    checks    = 0;
    cycle     = 0;
    clk       = 1'b0;
    rstn      = 1'b0;
    ex_stall  = 1'b0;
    flush     = 1'b0;
    flush_pc  = '0;
    if_pc     = '0;
    if_instr  = NOP;
    if_bubble = 1'b1;
    ex_info   = '{instr: NOP, bubble: 1'b1, writes_rd: 1'b0};
    mem_info  = '{instr: NOP, bubble: 1'b1, writes_rd: 1'b0};
    m_pc      = '0;
    m_instr   = NOP;
    m_bubble  = 1'b1;
    m_dec     = '0;
    m_byp     = '0;

    repeat (RESET_CYCLES) @(negedge clk);
    check_bit("reset id_bubble_out", 1'b1, id_bubble_out);
    check_dec("reset id_dec_out", '0, id_dec_out);
    check_pc("reset id_pc", '0, id_pc);
    rstn = 1'b1;

    for (cycle = 1; cycle <= NUM_CYCLES; cycle++) begin
      // Registered outputs from the last rising edge
      check_pc("id_pc", m_pc, id_pc);
      check_instr("id_instr", m_instr, id_instr);
      check_dec("id_dec_out", m_dec, id_dec_out);
      check_imm("id_imm", m_dec.imm[XLEN-1:0], id_imm);
      check_byp("id_byp", m_byp, id_byp);

      r         = rand32();
      flush     = (r[7:0] < 8'd13);
      ex_stall  = (r[15:8] < 8'd26);
      if_bubble = (r[23:16] < 8'd26);
      s         = rand32();
      t         = rand32();
      if_pc     = {s, t[31:2], 2'b00};
      s         = rand32();
      t         = rand32();
      flush_pc  = {s, t[31:2], 2'b00};
      if_instr  = gen_instr();
      ex_info   = gen_stage();
      mem_info  = gen_stage();
      #1;

      id_view = '{instr: m_instr, bubble: m_bubble, writes_rd: m_dec.writes_rd};
      d_m     = model_decode(if_instr);
      b_m     = model_byp(if_instr, d_m, id_view, ex_info, mem_info);
      if (flush) begin
        stall_m = 1'b0;
      end else if (ex_stall) begin
        stall_m = !if_bubble;
      end else begin
        stall_m = load_hazard(if_instr, d_m, id_view) || load_hazard(if_instr, d_m, ex_info);
      end
      check_bit("id_stall", stall_m, id_stall);
      check_bit("id_bubble_out", m_bubble | ex_stall | flush, id_bubble_out);
      check_reg("id_src1", ex_stall ? m_instr[19:15] : if_instr[19:15], id_src1);
      check_reg("id_src2", ex_stall ? m_instr[24:20] : if_instr[24:20], id_src2);

      @(posedge clk);
      if (flush) begin
        m_pc     = flush_pc;
        m_bubble = 1'b1;
        if (!ex_stall) begin
          m_instr = if_instr;
          m_byp   = b_m;
          m_dec   = d_m;
        end
        m_dec.exc = '0;
      end else if (!ex_stall) begin
        m_instr = if_instr;
        m_byp   = b_m;
        m_dec   = d_m;
        if (if_bubble || stall_m) m_dec.exc = '0;
        if (stall_m) begin
          // Held instruction turns into a bubble, PC stays
          m_bubble = 1'b1;
        end else begin
          m_pc     = if_pc;
          m_bubble = if_bubble;
        end
      end
      @(negedge clk);
    end

    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns before the test loop finished", WATCHDOG_NS);
    $display("Checks run: %0d, errors: %0d", checks, errors);
    $display("Testbench failed");
    $finish;
  end

endmodule

`default_nettype wire

/* list.f */
hdl/rv_isa_pkg.sv
hdl/id_pipe_pkg.sv
hdl/instr_decode.sv
hdl/hazard_detect.sv
hdl/id_register.sv
hdl/id_stage.sv
test/id_stage_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the ID stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -rf obj_dir "$LOG"

verilator --binary --timing --assert -j 0 --top-module id_stage_tb -f list.f
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

./obj_dir/Vid_stage_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "Testbench passed" "$LOG"; then
  exit 0
fi
exit 1
